/* files.f */
+incdir+hw
+incdir+sim
hw/stepper_pkg.sv
hw/table_rd_if.sv
hw/speed_table.sv
hw/slot_scheduler.sv
hw/motor_core.sv
hw/stepper_ctrl.sv
sim/stepper_tb.sv

/* hw/motor_core.sv */
`timescale 1ns/100ps

module motor_core #(
	parameter int motor_id = 0
) (
	input  logic                clk,
	input  logic                resetn,
	table_rd_if.core            rd,
	input  logic                start,
	input  logic                stop,
	input  logic                dir,
	input  stepper_pkg::step_t  steps,
	output logic                drive,
	output logic                dir_out,
	output logic                busy,
	output stepper_pkg::speed_t rt_speed
);

	stepper_pkg::speed_t   slot_cnt;  // own slots since last pulse
	stepper_pkg::speed_t   cnt_nx;
	stepper_pkg::step_t    remain;
	stepper_pkg::step_t    rem_nx;
	stepper_pkg::tbl_idx_t idx;
	stepper_pkg::tbl_idx_t idx_nx;
	logic                  my_slot;
	logic                  hit;
	logic                  stop_pend;

	assign my_slot               = rd.slot[motor_id];
	assign rd.req_addr[motor_id] = idx;

	assign cnt_nx = slot_cnt + 1'b1;
	assign hit    = cnt_nx >= rd.rd_data;  // zero entry acts as one
	assign rem_nx = remain - 1'b1;

	// accelerate while far from the end, mirror on the way down
	always_comb begin
		idx_nx = idx;
		if (rem_nx > stepper_pkg::step_t'(idx) && idx < rd.last_idx)
			idx_nx = idx + 1'b1;
		else if (rem_nx <= stepper_pkg::step_t'(idx) && idx != '0)
			idx_nx = idx - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy      <= 1'b0;
			drive     <= 1'b0;
			dir_out   <= 1'b0;
			rt_speed  <= '0;
			stop_pend <= 1'b0;
			slot_cnt  <= '0;
			remain    <= '0;
			idx       <= '0;
		end else begin
			drive <= 1'b0;
			if (!busy) begin
				if (start && steps != '0) begin
					busy     <= 1'b1;
					dir_out  <= dir;
					remain   <= steps;
					slot_cnt <= '0;
					idx      <= '0;
				end
				if (my_slot)
					rt_speed <= '0;  // idle reads back zero
			end else begin
				if (stop)
					stop_pend <= 1'b1;
				if (my_slot) begin
					if (stop_pend || stop) begin
						busy      <= 1'b0;
						stop_pend <= 1'b0;
						idx       <= '0;
						rt_speed  <= '0;
					end else begin
						rt_speed <= rd.rd_data;
						if (hit) begin
							drive    <= 1'b1;
							slot_cnt <= '0;
							remain   <= rem_nx;
							if (rem_nx == '0) begin
								busy <= 1'b0;
								idx  <= '0;  // park at entry 0 for the next move
							end else begin
								idx <= idx_nx;
							end
						end else begin
							slot_cnt <= cnt_nx;
						end
					end
				end
			end
		end
	end

	// the last pulse leaves together with busy, so look one cycle back
	assert property (@(posedge clk) disable iff (!resetn) drive |-> $past(busy))
		else $error("motor %0d drive pulse outside a move", motor_id);

endmodule

/* hw/slot_scheduler.sv */
`timescale 1ns/100ps
`include "stepper_consts.svh"

module slot_scheduler #(
	parameter int motor_nbr = `MOTOR_NBR_DEF
) (
	input  logic      clk,
	input  logic      resetn,
	table_rd_if.sched rd
);

	logic [`SLOT_PERIOD-1:0] ahead;    // slot as it will be two cycles on
	stepper_pkg::tbl_idx_t   nxt_addr;

	// rotating enable, one motor per cycle
	always_ff @(posedge clk) begin
		if (!resetn)
			rd.slot <= {{(`SLOT_PERIOD-1){1'b0}}, 1'b1};
		else
			rd.slot <= {rd.slot[`SLOT_PERIOD-2:0], rd.slot[`SLOT_PERIOD-1]};
	end

	assign ahead = {rd.slot[`SLOT_PERIOD-3:0], rd.slot[`SLOT_PERIOD-1 -: 2]};

	// and-or select, only one bit of ahead is set
	always_comb begin
		nxt_addr = '0;
		for (int k = 0; k < motor_nbr; k++) begin
			if (ahead[k])
				nxt_addr = nxt_addr | rd.req_addr[k];
		end
	end

	// address lands one cycle before the owner's slot, data on the slot itself
	always_ff @(posedge clk) begin
		rd.rd_addr <= nxt_addr;
	end

	assert property (@(posedge clk) disable iff (!resetn) $onehot(rd.slot))
		else $error("slot enable is not one-hot");

endmodule

/* hw/speed_table.sv */
`timescale 1ns/100ps

module speed_table (
	input  logic                clk,
	input  logic                resetn,
	input  logic                load,
	input  logic                wr_en,
	input  stepper_pkg::speed_t wr_data,
	table_rd_if.tbl             rd
);

	localparam int DEPTH = 2 ** $bits(stepper_pkg::tbl_idx_t);

	stepper_pkg::tbl_idx_t wr_addr;
	logic                  wrapped; // last entry already written
	logic                  wr_fire;
	stepper_pkg::speed_t   mem [DEPTH];

	assign wr_fire = load && wr_en;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_addr     <= '0;
			rd.last_idx <= '0;
			wrapped     <= 1'b0;
		end else if (!load) begin
			wr_addr <= '0;
			wrapped <= 1'b0;
		end else if (wr_en) begin
			wr_addr     <= wr_addr + 1'b1;
			rd.last_idx <= wr_addr;
			if (wr_addr == stepper_pkg::tbl_idx_t'(DEPTH - 1))
				wrapped <= 1'b1;
		end
	end

	// write port from load, read port from scheduler
	always_ff @(posedge clk) begin
		if (wr_fire)
			mem[wr_addr] <= wr_data;
		rd.rd_data <= mem[rd.rd_addr];
	end

	// a load longer than the table would overwrite entry 0 and break last_idx
	assert property (@(posedge clk) disable iff (!resetn) wr_fire |-> !wrapped)
		else $error("speed table written past its last entry");

endmodule

/* hw/stepper_consts.svh */
`ifndef STEPPER_CONSTS_SVH
`define STEPPER_CONSTS_SVH

`define SPEED_W 16       // table entry width
`define STEP_W 16        // step count width
`define TABLE_AW 6       // 64 table entries

// clocks between two turns of one motor, at least read latency + 1
`define SLOT_PERIOD 8

`define MOTOR_NBR_DEF 2

`endif

/* hw/stepper_ctrl.sv */
`timescale 1ns/100ps
`include "stepper_consts.svh"

module stepper_ctrl #(
	parameter int motor_nbr = `MOTOR_NBR_DEF
) (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  load,
	input  logic                  wr_en,
	input  stepper_pkg::speed_t   wr_data,
	input  logic [motor_nbr-1:0]  start,
	input  logic [motor_nbr-1:0]  stop,
	input  logic [motor_nbr-1:0]  dir,
	input  stepper_pkg::step_t    steps [motor_nbr],
	output logic [motor_nbr-1:0]  drive,
	output logic [motor_nbr-1:0]  dir_out,
	output logic [motor_nbr-1:0]  busy,
	output stepper_pkg::speed_t   rt_speed [motor_nbr]
);

	table_rd_if #(.motor_nbr(motor_nbr)) rd_bus ();

	speed_table i_speed_table (
		.clk     (clk),
		.resetn  (resetn),
		.load    (load),
		.wr_en   (wr_en),
		.wr_data (wr_data),
		.rd      (rd_bus)
	);

	slot_scheduler #(.motor_nbr(motor_nbr)) i_slot_scheduler (
		.clk    (clk),
		.resetn (resetn),
		.rd     (rd_bus)
	);

	for (genvar k = 0; k < motor_nbr; k++) begin : g_motor
		motor_core #(.motor_id(k)) i_motor_core (
			.clk      (clk),
			.resetn   (resetn),
			.rd       (rd_bus),
			.start    (start[k]),
			.stop     (stop[k]),
			.dir      (dir[k]),
			.steps    (steps[k]),
			.drive    (drive[k]),
			.dir_out  (dir_out[k]),
			.busy     (busy[k]),
			.rt_speed (rt_speed[k])
		);
	end

endmodule

/* hw/stepper_pkg.sv */
`include "stepper_consts.svh"

package stepper_pkg;

	// number of own slots between two drive pulses
	typedef logic [`SPEED_W-1:0] speed_t;

	// remaining or commanded drive pulses
	typedef logic [`STEP_W-1:0] step_t;

	typedef logic [`TABLE_AW-1:0] tbl_idx_t;

endpackage

/* hw/table_rd_if.sv */
`timescale 1ns/100ps
`include "stepper_consts.svh"

interface table_rd_if #(
	parameter int motor_nbr = `MOTOR_NBR_DEF
);

	logic [`SLOT_PERIOD-1:0] slot;                 // one-hot, bit k is motor k's turn
	logic [`TABLE_AW-1:0]    req_addr [motor_nbr]; // current index of each motor
	logic [`TABLE_AW-1:0]    rd_addr;
	logic [`SPEED_W-1:0]     rd_data;              // seen by all cores
	logic [`TABLE_AW-1:0]    last_idx;             // highest loaded entry

	modport tbl (input rd_addr, output rd_data, output last_idx);

	modport sched (output slot, output rd_addr, input req_addr);

	modport core (input slot, output req_addr, input rd_data, input last_idx);

endinterface

/* run.sh */
#!/bin/sh
# build the stepper testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module stepper_tb -o stepper_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/stepper_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Everything OK" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* sim/stepper_tests.svh */
`ifndef STEPPER_TESTS_SVH
`define STEPPER_TESTS_SVH

task automatic test_single_move();
	int                 err0;
	int                 b0;
	stepper_pkg::step_t n;
	logic               d;
	err0 = errors;
	load_table();
	n  = stepper_pkg::step_t'(10 + take_bits(5) % 31);
	d  = take_bits(1) != 0;
	b0 = pulse_cnt[0];
	launch(2'b01, n, '0, {1'b0, d});
	wait_idle(2'b01);
	check_step("pulse_cnt[0]", stepper_pkg::step_t'(pulse_cnt[0] - b0), n);
	check_bit("dir_out[0]", dir_out[0], d);
	repeat (2 * `SLOT_PERIOD) @(negedge clk);  // nothing may follow busy falling
	check_step("pulse_cnt[0] after idle", stepper_pkg::step_t'(pulse_cnt[0] - b0), n);
	report("test 1 single move", err0);
endtask

task automatic test_pulse_timing();
	int                 err0;
	int                 base;
	int                 idx;
	int                 rem;
	int                 gap;
	stepper_pkg::step_t n;
	err0 = errors;
	n    = stepper_pkg::step_t'(10 + take_bits(5) % 31);
	base = pulse_cyc.size();
	launch(2'b01, n, '0, 2'b00);
	wait_idle(2'b01);
	check_step("pulse_cnt[0]", stepper_pkg::step_t'(pulse_cyc.size() - base), n);
	idx = 0;
	rem = int'(n);
	for (int p = base; p < pulse_cyc.size(); p++) begin
		check_speed("rt_speed[0]", pulse_spd[p], tbl[idx]);
		rem--;
		idx = next_index(idx, rem, TBL_LEN - 1);
		if (p + 1 < pulse_cyc.size()) begin
			gap = pulse_cyc[p + 1] - pulse_cyc[p];
			check_speed("pulse gap", stepper_pkg::speed_t'(gap),
				stepper_pkg::speed_t'(int'(tbl[idx]) * `SLOT_PERIOD));
		end
	end
	report("test 2 pulse timing", err0);
endtask

task automatic test_stop();
	int                 err0;
	int                 b1;
	stepper_pkg::step_t n;
	err0 = errors;
	n    = stepper_pkg::step_t'(20 + take_bits(5) % 21);
	b1   = pulse_cnt[1];
	launch(2'b10, '0, n, 2'b10);
	wait_pulses(1, b1 + 3);
	@(posedge clk);
	stop <= 2'b10;
	@(posedge clk);
	stop <= 2'b00;
	wait_idle(2'b10);
	checks++;
	if (pulse_cnt[1] - b1 > 4) begin
		errors++;
		$display("Fail pulse_cnt[1] got %h limit %h", pulse_cnt[1] - b1, 4);
	end
	check_speed("rt_speed[1]", rt_speed[1], '0);
	check_bit("dir_out[1]", dir_out[1], 1'b1);
	report("test 3 stop", err0);
endtask

task automatic test_two_motors();
	int                 err0;
	int                 b0;
	int                 b1;
	stepper_pkg::step_t n0;
	stepper_pkg::step_t n1;
	logic [1:0]         d;
	err0 = errors;
	n0   = stepper_pkg::step_t'(10 + take_bits(5) % 31);
	n1   = stepper_pkg::step_t'(10 + take_bits(5) % 31);
	if (n1 == n0)
		n1 = n1 + 1'b1;
	d[0] = take_bits(1) != 0;
	d[1] = !d[0];  // opposite directions
	b0   = pulse_cnt[0];
	b1   = pulse_cnt[1];
	launch(2'b11, n0, n1, d);
	wait_idle(2'b11);
	check_step("pulse_cnt[0]", stepper_pkg::step_t'(pulse_cnt[0] - b0), n0);
	check_step("pulse_cnt[1]", stepper_pkg::step_t'(pulse_cnt[1] - b1), n1);
	check_bit("dir_out[0]", dir_out[0], d[0]);
	check_bit("dir_out[1]", dir_out[1], d[1]);
	report("test 4 two motors", err0);
endtask

task automatic test_restart_ignored();
	int                 err0;
	int                 b0;
	stepper_pkg::step_t n;
	logic               d;
	err0 = errors;
	n    = stepper_pkg::step_t'(10 + take_bits(5) % 31);
	d    = take_bits(1) != 0;
	b0   = pulse_cnt[0];
	launch(2'b01, n, '0, {1'b0, d});
	wait_pulses(0, b0 + 2);
	launch(2'b01, n + stepper_pkg::step_t'(5), '0, {1'b0, !d});
	wait_idle(2'b01);
	check_step("pulse_cnt[0]", stepper_pkg::step_t'(pulse_cnt[0] - b0), n);
	check_bit("dir_out[0]", dir_out[0], d);
	report("test 5 start while busy", err0);
endtask

`endif

/* sim/stepper_tb.sv */
`timescale 1ns/100ps
`include "stepper_consts.svh"

module stepper_tb;

	localparam int MOTORS     = 2;
	localparam int MAX_STEPS  = 41;
	localparam int MAX_ENTRY  = 4;
	localparam int MOVES      = 6;
	localparam int TBL_LEN    = 8;
	localparam int IDLE_LIMIT = (MAX_STEPS + 2) * MAX_ENTRY * `SLOT_PERIOD;
	// every move at the slowest entry, doubled for slot phase and table load
	localparam int WD_CYCLES  = 2 * MOVES * MAX_STEPS * MAX_ENTRY * `SLOT_PERIOD + 500;

	logic                clk;
	logic                resetn;
	logic                load;
	logic                wr_en;
	stepper_pkg::speed_t wr_data;
	logic [MOTORS-1:0]   start;
	logic [MOTORS-1:0]   stop;
	logic [MOTORS-1:0]   dir;
	stepper_pkg::step_t  steps [MOTORS];
	logic [MOTORS-1:0]   drive;
	logic [MOTORS-1:0]   dir_out;
	logic [MOTORS-1:0]   busy;
	stepper_pkg::speed_t rt_speed [MOTORS];

	stepper_pkg::speed_t tbl [TBL_LEN];        // copy of the loaded table
	logic [31:0]         lfsr = 32'hb8bfc57f;
	int                  cyc = 0;
	int                  pulse_cnt [MOTORS] = '{0, 0};
	int                  pulse_cyc [$];        // motor 0 only
	stepper_pkg::speed_t pulse_spd [$];
	int                  errors = 0;
	int                  checks = 0;
	int                  tests = 0;

	stepper_ctrl #(.motor_nbr(MOTORS)) i_stepper_ctrl (
		.clk      (clk),
		.resetn   (resetn),
		.load     (load),
		.wr_en    (wr_en),
		.wr_data  (wr_data),
		.start    (start),
		.stop     (stop),
		.dir      (dir),
		.steps    (steps),
		.drive    (drive),
		.dir_out  (dir_out),
		.busy     (busy),
		.rt_speed (rt_speed)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	always @(posedge clk) begin
		if (resetn) begin
			for (int m = 0; m < MOTORS; m++) begin
				if (drive[m])
					pulse_cnt[m]++;
			end
			if (drive[0]) begin
				pulse_cyc.push_back(cyc);
				pulse_spd.push_back(rt_speed[0]);
			end
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
	endfunction

	function int take_bits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r = (r << 1) | int'(lfsr[0]);
		end
		return r;
	endfunction

	// acceleration rule applied after each pulse
	function automatic int next_index(input int idx, input int rem, input int last);
		if (rem > idx && idx < last)
			return idx + 1;
		if (rem <= idx && idx > 0)
			return idx - 1;
		return idx;
	endfunction

	task automatic check_speed(input string name, input stepper_pkg::speed_t got,
			input stepper_pkg::speed_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_step(input string name, input stepper_pkg::step_t got,
			input stepper_pkg::step_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic load_table();
		int e;
		e = MAX_ENTRY;
		for (int i = 0; i < TBL_LEN; i++) begin
			if (i > 0 && e > 1 && take_bits(1) != 0)
				e = e - 1;  // non-increasing, faster further up
			tbl[i] = stepper_pkg::speed_t'(e);
		end
		@(posedge clk);
		load <= 1'b1;
		for (int i = 0; i < TBL_LEN; i++) begin
			wr_en   <= 1'b1;
			wr_data <= tbl[i];
			@(posedge clk);
		end
		wr_en <= 1'b0;
		load  <= 1'b0;
		@(posedge clk);
	endtask

	task automatic launch(input logic [1:0] mask, input stepper_pkg::step_t s0,
			input stepper_pkg::step_t s1, input logic [1:0] d);
		@(posedge clk);
		steps[0] <= s0;
		steps[1] <= s1;
		dir      <= d;
		start    <= mask;
		@(posedge clk);
		start <= '0;
	endtask

	task automatic wait_idle(input logic [1:0] mask);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while ((busy & mask) != 2'b00 && n < IDLE_LIMIT);
		if ((busy & mask) != 2'b00) begin
			errors++;
			$display("motors %b still busy after %0d cycles", mask, n);
		end
		@(negedge clk);  // last pulse reaches the counters
	endtask

	task automatic wait_pulses(input int m, input int n);
		int t;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (pulse_cnt[m] < n && t < IDLE_LIMIT);
		if (pulse_cnt[m] < n) begin
			errors++;
			$display("motor %0d made only %0d of %0d pulses in time", m, pulse_cnt[m], n);
		end
	endtask

	task automatic report(input string name, input int err0);
		tests++;
		if (errors == err0)
			$display("%s: passed", name);
		else
			$display("%s: failed with %0d errors", name, errors - err0);
	endtask

	`include "stepper_tests.svh"

	initial begin
		resetn   = 1'b0;
		load     = 1'b0;
		wr_en    = 1'b0;
		wr_data  = '0;
		start    = '0;
		stop     = '0;
		dir      = '0;
		steps[0] = '0;
		steps[1] = '0;
		repeat (8) @(posedge clk);
		resetn <= 1'b1;
		repeat (2) @(posedge clk);
		test_single_move();
		test_pulse_timing();
		test_stop();
		test_two_motors();
		test_restart_ignored();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial begin
		repeat (WD_CYCLES) @(posedge clk);
		$display("watchdog expired before the tests finished");
		$display("Something failed");
		$finish;
	end

endmodule
